// File: list.f
+incdir+source
source/avmm_bus_pkg.sv
source/burst_ctl_pkg.sv
source/burst_sop_tracker.sv
source/burst_count_gearbox.sv
source/avmm_burst_mapper.sv
source/burst_sram_slave.sv
source/burst_map_top.sv
tests/burst_map_properties.sv
tests/burst_map_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the burst mapper testbench with Verilator and run it from the project root.
# The run counts as passed only when the testbench prints its pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module burst_map_tb -o burst_map_sim &&
./obj_dir/burst_map_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }

// File: source/avmm_burst_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avalon burst mapper
// Maps master bursts of up to 32 beats onto a slave limited to 4
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module avmm_burst_mapper
    import avmm_bus_pkg::*;
    import burst_ctl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Wide-burst master port
    input  avmm_req_t   m_req,
    output logic        m_waitrequest,
    output avmm_rsp_t   m_rsp,

    // Narrow-burst slave port
    output avmm_s_req_t s_req,
    input  logic        s_waitrequest,
    input  avmm_rsp_t   s_rsp
);

    // Gearbox handshakes and outputs
    logic     req_complete;
    logic     m_new_req;
    logic     s_accept_req;
    addr_t    gear_addr;
    s_burst_t gear_burstcount;

    // First-beat flags from the two write trackers
    logic m_wr_sop;
    logic s_wr_sop;

    // Registered command and data, one cycle behind master acceptance
    logic        s_read_q;
    logic        s_write_q;
    data_t       s_writedata_q;
    byteenable_t s_byteenable_q;

    // Write beats map one to one, so only a split read holds the master
    assign m_waitrequest = s_waitrequest || (s_read_q && !req_complete);

    // Reads and first write beats are the only flits that carry a burst
    assign m_new_req = (m_req.read || m_req.write) && !m_waitrequest && m_wr_sop;

    // A slave burst is taken on a read or a slave first write beat
    assign s_accept_req = (s_read_q || s_write_q) && !s_waitrequest && s_wr_sop;

    burst_count_gearbox gearbox_inst
    (
        .clk            (clk),
        .reset          (reset),
        .m_new_req      (m_new_req),
        .m_addr         (m_req.address),
        .m_burstcount   (m_req.burstcount),
        .s_accept_req   (s_accept_req),
        .s_req_complete (req_complete),
        .s_addr         (gear_addr),
        .s_burstcount   (gear_burstcount)
    );

    // Everything the gearbox does not hold moves forward whenever the
    // master is not stalled, and stays put under back-pressure
    always_ff @(posedge clk)
    begin
        if (!m_waitrequest)
        begin
            s_read_q <= m_req.read;
            s_write_q <= m_req.write;
            s_writedata_q <= m_req.writedata;
            s_byteenable_q <= m_req.byteenable;
        end

        if (reset)
        begin
            s_read_q <= 1'b0;
            s_write_q <= 1'b0;
        end
    end

    // Address and count are only valid on slave first beats
    // The slave tracker sits at a first beat between writes, which covers reads
    always_comb
    begin
        s_req.read = s_read_q;
        s_req.write = s_write_q;
        s_req.writedata = s_writedata_q;
        s_req.byteenable = s_byteenable_q;
        s_req.address = s_wr_sop ? gear_addr : '0;
        s_req.burstcount = s_wr_sop ? gear_burstcount : '0;
    end

    // Read responses carry no burst information and pass straight back
    assign m_rsp = s_rsp;

    // Master side tracker follows the wide bursts
    burst_sop_tracker m_sop_tracker_inst
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (m_req.write && !m_waitrequest),
        .burstcount (m_req.burstcount),
        .sop        (m_wr_sop)
    );

    // Slave side tracker sees the narrow count widened to the master width
    burst_sop_tracker s_sop_tracker_inst
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (s_write_q && !s_waitrequest),
        .burstcount (m_burst_t'(s_req.burstcount)),
        .sop        (s_wr_sop)
    );

endmodule

// File: source/avmm_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avalon bus types
// Vectors and master-side request and response structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "burst_map_settings.svh"

package avmm_bus_pkg;

    // Word address on both sides of the mapper
    typedef logic [`BM_ADDR_WIDTH-1:0] addr_t;

    typedef logic [`BM_DATA_WIDTH-1:0] data_t;

    // One enable bit per byte lane of the data word
    typedef logic [`BM_DATA_WIDTH/8-1:0] byteenable_t;

    // Master burst count, 1 up to 32 beats
    typedef logic [`BM_M_BURST_WIDTH-1:0] m_burst_t;

    // Command flit as issued by the master
    // Address and burstcount matter only on reads and on first write beats
    typedef struct packed
    {
        logic        read;
        logic        write;
        addr_t       address;
        m_burst_t    burstcount;
        data_t       writedata;
        byteenable_t byteenable;
    } avmm_req_t;

    // Read data returns one beat per readdatavalid pulse
    typedef struct packed
    {
        logic  readdatavalid;
        data_t readdata;
    } avmm_rsp_t;

endpackage

// File: source/burst_count_gearbox.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst count gearbox
// Splits one master burst into a run of legal slave bursts with addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "burst_map_settings.svh"

module burst_count_gearbox
    import avmm_bus_pkg::*;
    import burst_ctl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Master side, sampled when a read or a first write beat is accepted
    input  logic     m_new_req,
    input  addr_t    m_addr,
    input  m_burst_t m_burstcount,

    // Slave side, one step per accepted slave burst
    input  logic     s_accept_req,
    output logic     s_req_complete,
    output addr_t    s_addr,
    output s_burst_t s_burstcount
);

    // Largest slave burst, 4 beats with a 3 bit count
    localparam int MaxSlaveBeats = 1 << (`BM_S_BURST_WIDTH - 1);

    gear_state_e state;

    // Start address and beats left of the slave burst now on offer
    addr_t    cur_addr;
    m_burst_t beats_left;

    // Size of the slave burst now on offer, widened to the master count
    m_burst_t next_beats;

    // Pick the size of the next slave burst from the address and the beats left
    always_comb
    begin
        next_beats = m_burst_t'(1);
        if (`BM_NATURAL_ALIGNMENT != 0)
        begin
            // Walk up the powers of two and keep the largest one that fits
            // Alignment to a size implies alignment to every smaller size
            for (int i = 0; i < `BM_S_BURST_WIDTH; i++)
            begin
                if ((m_burst_t'(1 << i) <= beats_left) &&
                    ((cur_addr & addr_t'((1 << i) - 1)) == '0))
                begin
                    next_beats = m_burst_t'(1 << i);
                end
            end
        end
        else
        begin
            // No alignment rule, just cap the remainder at the slave limit
            if (beats_left > m_burst_t'(MaxSlaveBeats))
                next_beats = m_burst_t'(MaxSlaveBeats);
            else
                next_beats = beats_left;
        end
    end

    assign s_addr = cur_addr;
    assign s_burstcount = s_burst_t'(next_beats);

    // The burst on offer covers everything that is left
    assign s_req_complete = (state == gear_split) && (next_beats == beats_left);

    always_ff @(posedge clk)
    begin
        case (state)
            gear_idle:
            begin
                if (m_new_req)
                begin
                    cur_addr <= m_addr;
                    beats_left <= m_burstcount;
                    state <= gear_split;
                end
            end

            gear_split:
            begin
                // A new master request may arrive in the same cycle as the
                // last slave burst is taken, so loading wins over advancing
                if (m_new_req)
                begin
                    cur_addr <= m_addr;
                    beats_left <= m_burstcount;
                end
                else if (s_accept_req)
                begin
                    cur_addr <= cur_addr + addr_t'(next_beats);
                    beats_left <= beats_left - next_beats;
                    if (s_req_complete)
                        state <= gear_idle;
                end
            end

            default:
            begin
                state <= gear_idle;
            end
        endcase

        if (reset)
        begin
            state <= gear_idle;
            beats_left <= '0;
        end
    end

endmodule

// File: source/burst_ctl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst control types
// Slave burst count, slave request and gearbox states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "burst_map_settings.svh"

package burst_ctl_pkg;

    import avmm_bus_pkg::*;

    // Slave burst count, 1 up to 4 beats
    typedef logic [`BM_S_BURST_WIDTH-1:0] s_burst_t;

    // Slave-side command, identical to the master flit except for burstcount
    typedef struct packed
    {
        logic        read;
        logic        write;
        addr_t       address;
        s_burst_t    burstcount;
        data_t       writedata;
        byteenable_t byteenable;
    } avmm_s_req_t;

    // Idle waits for a master request, split walks through its slave bursts
    typedef enum logic
    {
        gear_idle,
        gear_split
    } gear_state_e;

endpackage

// File: source/burst_map_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst mapper settings
// Bus widths, memory depth, read latency and the alignment switch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BURST_MAP_SETTINGS_SVH
`define BURST_MAP_SETTINGS_SVH

// Word address width, one address per data word
`define BM_ADDR_WIDTH 8
`define BM_DATA_WIDTH 32

// Master bursts reach 32 beats, slave bursts stop at 4
`define BM_M_BURST_WIDTH 6
`define BM_S_BURST_WIDTH 3

// Set to 1 when every slave burst must sit on a multiple of its own size
`define BM_NATURAL_ALIGNMENT 1

// Cycles from an accepted read to its first data beat, at least 2
`define BM_READ_LATENCY 2
`define BM_MEM_WORDS 256

`endif

// File: source/burst_map_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst mapper top level
// Burst mapper in front of the on-chip memory slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module burst_map_top
    import avmm_bus_pkg::*;
    import burst_ctl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  avmm_req_t m_req,
    output logic      m_waitrequest,
    output avmm_rsp_t m_rsp
);

    // Internal slave-side bus between mapper and memory
    avmm_s_req_t s_req;
    logic        s_waitrequest;
    avmm_rsp_t   s_rsp;

    avmm_burst_mapper mapper_inst
    (
        .clk           (clk),
        .reset         (reset),
        .m_req         (m_req),
        .m_waitrequest (m_waitrequest),
        .m_rsp         (m_rsp),
        .s_req         (s_req),
        .s_waitrequest (s_waitrequest),
        .s_rsp         (s_rsp)
    );

    burst_sram_slave sram_inst
    (
        .clk           (clk),
        .reset         (reset),
        .s_req         (s_req),
        .s_waitrequest (s_waitrequest),
        .s_rsp         (s_rsp)
    );

endmodule

// File: source/burst_sop_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write burst first-beat tracker
// Counts accepted write beats and flags the first beat of each burst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module burst_sop_tracker
    import avmm_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // One accepted write beat
    input  logic     flit_valid,
    // Only sampled on a first beat
    input  m_burst_t burstcount,
    output logic     sop
);

    // Beats still owed by the current write burst
    m_burst_t beats_left;

    // Nothing owed means the next accepted beat opens a new burst
    assign sop = (beats_left == '0);

    always_ff @(posedge clk)
    begin
        if (flit_valid)
        begin
            // The first beat counts itself, so one less is still to come
            if (sop)
                beats_left <= burstcount - m_burst_t'(1);
            else
                beats_left <= beats_left - m_burst_t'(1);
        end

        if (reset)
            beats_left <= '0;
    end

endmodule

// File: source/burst_sram_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst SRAM slave
// On-chip word memory taking slave bursts, fixed read latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "burst_map_settings.svh"

module burst_sram_slave
    import avmm_bus_pkg::*;
    import burst_ctl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  avmm_s_req_t s_req,
    output logic        s_waitrequest,
    output avmm_rsp_t   s_rsp
);

    // Cycles spent waiting after acceptance, the output register adds one more
    localparam int LatencyWait = `BM_READ_LATENCY - 2;

    data_t mem [`BM_MEM_WORDS];

    // Write burst position, zero beats left means a first beat is expected
    s_burst_t wr_left;
    s_burst_t wr_offset;
    addr_t    wr_base;
    addr_t    wr_addr;
    logic     wr_accept;

    // Read sequencer state
    logic       rd_busy;
    logic [3:0] rd_wait;
    addr_t      rd_addr;
    s_burst_t   rd_left;
    logic       rd_accept;

    avmm_rsp_t rsp_q;

    // The only back-pressure is an unfinished read burst
    assign s_waitrequest = rd_busy;

    assign wr_accept = s_req.write && !rd_busy;
    assign rd_accept = s_req.read && !rd_busy;

    // First beat lands at the burst address, later beats at base plus index
    assign wr_addr = (wr_left == '0) ? s_req.address : wr_base + addr_t'(wr_offset);

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            if (wr_left == '0)
            begin
                wr_base <= s_req.address;
                wr_offset <= s_burst_t'(1);
                wr_left <= s_req.burstcount - s_burst_t'(1);
            end
            else
            begin
                wr_offset <= wr_offset + s_burst_t'(1);
                wr_left <= wr_left - s_burst_t'(1);
            end
        end

        if (reset)
            wr_left <= '0;
    end

    // Byte lanes are written only where byteenable is set
    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            for (int b = 0; b < `BM_DATA_WIDTH / 8; b++)
            begin
                if (s_req.byteenable[b])
                    mem[wr_addr][b*8 +: 8] <= s_req.writedata[b*8 +: 8];
            end
        end
    end

    // Wait out the latency, then stream one beat per cycle
    always_ff @(posedge clk)
    begin
        rsp_q.readdatavalid <= 1'b0;

        if (rd_accept)
        begin
            rd_busy <= 1'b1;
            rd_addr <= s_req.address;
            rd_left <= s_req.burstcount;
            rd_wait <= 4'(LatencyWait);
        end
        else if (rd_busy)
        begin
            if (rd_wait != '0)
            begin
                rd_wait <= rd_wait - 4'd1;
            end
            else
            begin
                rsp_q.readdatavalid <= 1'b1;
                rsp_q.readdata <= mem[rd_addr];
                rd_addr <= rd_addr + addr_t'(1);
                rd_left <= rd_left - s_burst_t'(1);
                // Release the bus as the last beat goes out
                if (rd_left == s_burst_t'(1))
                    rd_busy <= 1'b0;
            end
        end

        if (reset)
        begin
            rd_busy <= 1'b0;
            rd_wait <= '0;
            rsp_q.readdatavalid <= 1'b0;
        end
    end

    assign s_rsp = rsp_q;

endmodule

// File: tests/burst_map_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slave bus properties
// Burst count range, natural alignment and request hold on the mapper
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "burst_map_settings.svh"

module burst_map_properties
    import avmm_bus_pkg::*;
    import burst_ctl_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input avmm_s_req_t s_req,
    input logic        s_waitrequest,
    input logic        s_wr_sop
);

    // Reads and slave first write beats are the flits that carry a burst
    logic burst_flit;

    assign burst_flit = s_req.read || (s_req.write && s_wr_sop);

    // A slave burst is 1 to 4 beats long
    count_range: assert property (@(posedge clk) disable iff (reset)
        burst_flit |-> (s_req.burstcount != '0) && (s_req.burstcount <= s_burst_t'(4)))
        else $error("slave burstcount outside 1 to 4");

    // With alignment on, every slave burst starts on a multiple of its size
    natural_alignment: assert property (@(posedge clk) disable iff (reset)
        (burst_flit && (s_req.burstcount != '0)) |->
        ((`BM_NATURAL_ALIGNMENT == 0) ||
         ((s_req.address % addr_t'(s_req.burstcount)) == '0)))
        else $error("slave burst address not aligned to its burstcount");

    // A stalled request stays on the bus unchanged
    request_hold: assert property (@(posedge clk) disable iff (reset)
        ((s_req.read || s_req.write) && s_waitrequest) |=> $stable(s_req))
        else $error("slave request changed while waitrequest was high");

endmodule

bind avmm_burst_mapper burst_map_properties properties_inst
(
    .clk           (clk),
    .reset         (reset),
    .s_req         (s_req),
    .s_waitrequest (s_waitrequest),
    .s_wr_sop      (s_wr_sop)
);

// File: tests/burst_map_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst mapper testbench
// Replays write and read bursts from the data file and checks read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module burst_map_tb
    import avmm_bus_pkg::*;
;

    localparam int reset_cycles = 8;
    localparam int cycles_per_cmd = 40;

    logic      clk;
    logic      reset;
    avmm_req_t m_req;
    logic      m_waitrequest;
    avmm_rsp_t m_rsp;

    // Commands as read from the data file
    byte      cmd_op[$];
    addr_t    cmd_addr[$];
    m_burst_t cmd_count[$];
    data_t    cmd_word[$];

    // Expected beats in arrival order, each tagged with the read it belongs to
    data_t    exp_data[$];
    int       exp_read[$];
    m_burst_t exp_count[$];
    m_burst_t rcv_count[$];

    int data_errors = 0;
    int count_errors = 0;
    int flag_errors = 0;

    logic [31:0] lfsr_state = 32'h3ba3_a2a2;

    burst_map_top burst_map_top_inst
    (
        .clk           (clk),
        .reset         (reset),
        .m_req         (m_req),
        .m_waitrequest (m_waitrequest),
        .m_rsp         (m_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    task automatic check_data(input data_t actual, input data_t expected, input string what);
        if (actual !== expected)
        begin
            data_errors++;
            $display("ERROR %0t ns: %s read %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input m_burst_t actual, input m_burst_t expected, input int idx);
        if (actual !== expected)
        begin
            count_errors++;
            $display("ERROR %0t ns: read %0d returned %0d beats, expected %0d",
                     $time, idx, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            flag_errors++;
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Each idle cycle ends just after the rising edge, where inputs are driven
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Hold one flit until a cycle with waitrequest low takes it
    task automatic send_flit(input avmm_req_t flit);
        logic accepted;
        accepted = 1'b0;
        m_req = flit;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = (m_waitrequest === 1'b0);
            @(posedge clk);
            #1;
        end
        m_req = '0;
    endtask

    task automatic write_burst(input addr_t addr, input m_burst_t count, input data_t word);
        avmm_req_t flit;
        for (int b = 0; b < int'(count); b++)
        begin
            flit = '0;
            flit.write = 1'b1;
            flit.address = addr;
            flit.burstcount = count;
            flit.writedata = word + data_t'(b);
            flit.byteenable = '1;
            send_flit(flit);
            // Idle beats inside the burst must not look like a new burst
            if (b < int'(count) - 1)
                idle_cycles(random_bits(1));
        end
    endtask

    // Expected beats are queued before the command goes out
    task automatic read_burst(input addr_t addr, input m_burst_t count, input data_t word);
        avmm_req_t flit;
        for (int b = 0; b < int'(count); b++)
        begin
            exp_data.push_back(word + data_t'(b));
            exp_read.push_back(exp_count.size());
        end
        exp_count.push_back(count);
        rcv_count.push_back('0);
        flit = '0;
        flit.read = 1'b1;
        flit.address = addr;
        flit.burstcount = count;
        flit.byteenable = '1;
        send_flit(flit);
    endtask

    // Sampled mid-cycle, where the registered response is settled
    always @(negedge clk)
    begin
        if (reset === 1'b0 && m_rsp.readdatavalid === 1'b1)
        begin
            if (exp_data.size() == 0)
            begin
                data_errors++;
                $display("ERROR %0t ns: read beat %h arrived with no read pending",
                         $time, m_rsp.readdata);
            end
            else
            begin
                int idx;
                idx = exp_read.pop_front();
                check_data(m_rsp.readdata, exp_data.pop_front(), "read beat");
                rcv_count[idx] = rcv_count[idx] + m_burst_t'(1);
            end
        end
    end

    initial
    begin
        int fd;
        int n;
        string line;
        byte t_op;
        logic [31:0] t_addr;
        logic [31:0] t_count;
        logic [31:0] t_word;
        logic prev_read;

        reset = 1'b1;
        m_req = '0;

        fd = $fopen("tests/burst_map_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open tests/burst_map_testdata.txt");
            $display("Test failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() == 0 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%c %h %d %h", t_op, t_addr, t_count, t_word);
                if (n == 4)
                begin
                    cmd_op.push_back(t_op);
                    cmd_addr.push_back(addr_t'(t_addr));
                    cmd_count.push_back(m_burst_t'(t_count));
                    cmd_word.push_back(data_t'(t_word));
                end
            end
            $fclose(fd);

            repeat (reset_cycles) @(posedge clk);
            #1;
            reset = 1'b0;

            // Quiet bus right after reset
            repeat (4)
            begin
                @(negedge clk);
                check_flag(m_waitrequest, 1'b0, "m_waitrequest after reset");
                check_flag(m_rsp.readdatavalid, 1'b0, "readdatavalid after reset");
            end
            @(posedge clk);
            #1;

            // Consecutive reads go out with no idle cycle between them
            prev_read = 1'b0;
            for (int i = 0; i < cmd_op.size(); i++)
            begin
                if (cmd_op[i] == "W" || !prev_read)
                    idle_cycles(random_bits(2));
                if (cmd_op[i] == "W")
                    write_burst(cmd_addr[i], cmd_count[i], cmd_word[i]);
                else
                    read_burst(cmd_addr[i], cmd_count[i], cmd_word[i]);
                prev_read = (cmd_op[i] != "W");
            end

            // Drain outstanding beats, then give stray extra beats time to show
            while (exp_data.size() != 0)
                @(posedge clk);
            repeat (20) @(posedge clk);

            for (int i = 0; i < exp_count.size(); i++)
                check_count(rcv_count[i], exp_count[i], i);

            $display("Errors: data %0d, count %0d, flag %0d",
                     data_errors, count_errors, flag_errors);
            if (data_errors + count_errors + flag_errors == 0)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

    // Budget of 40 cycles per command line on top of the reset time
    initial
    begin
        #1;
        repeat (reset_cycles + cycles_per_cmd * cmd_op.size()) @(posedge clk);
        $display("The run timed out with %0d read beats still missing", exp_data.size());
        $display("Test failed");
        $finish;
    end

endmodule

// File: tests/burst_map_testdata.txt
# Columns: op (W or R), word address (hex), burstcount (decimal), first word (hex)
# A write puts first word + i on beat i, a read expects first word + i on beat i
W 40 1 12345678
R 40 1 12345678
W 13 32 a0000000
R 13 32 a0000000
R 16 5 a0000003
R 1e 3 a000000b
R 22 7 a000000f
W ff 1 0badf00d
R 13 4 a0000000
R 2d 6 a000001a
R 17 2 a0000004
R 20 9 a000000d
R ff 1 0badf00d
W 80 8 b0000000
W 8b 5 c0000000
W 96 12 d0000000
W 41 3 e0000000
W c5 16 f0000000
W 03 7 99990000
R 80 8 b0000000
R 8b 5 c0000000
R 96 12 d0000000
R 41 3 e0000000
R c5 16 f0000000
R 84 2 b0000004
R 05 4 99990002
R 03 7 99990000
R 9b 7 d0000005
